// File: alu.sv
module alu import rv_exec_pkg::*; (
    input  alu_op_t op,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   imm,
    input  logic    use_imm,
    output word_t   result
);

    word_t      op_b;
    logic [4:0] shamt;

    assign op_b  = use_imm ? imm : rs2_data;

    // shifts use only the low five bits.
    assign shamt = op_b[4:0];

    always_comb begin
        case (op)
            alu_add:      result = rs1_data + op_b;
            alu_sub:      result = rs1_data - op_b;
            alu_sll:      result = rs1_data << shamt;
            alu_slt:      result = word_t'($signed(rs1_data) < $signed(op_b));
            alu_sltu:     result = word_t'(rs1_data < op_b);
            alu_xor:      result = rs1_data ^ op_b;
            alu_srl:      result = rs1_data >> shamt;
            alu_sra:      result = word_t'($signed(rs1_data) >>> shamt);
            alu_or:       result = rs1_data | op_b;
            alu_and:      result = rs1_data & op_b;
            alu_pass_imm: result = imm;
            default:      result = '0;
        endcase
    end

endmodule

// File: instr_decoder.sv
module instr_decoder import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      ex_valid,
    output alu_op_t   ex_op,
    output reg_addr_t ex_rs1,
    output reg_addr_t ex_rs2,
    output reg_addr_t ex_rd,
    output word_t     ex_imm,
    output logic      ex_use_imm,
    output logic      illegal
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      shamt_imm;
    word_t      u_imm;

    alu_op_t    dec_op;
    word_t      dec_imm;
    logic       dec_use_imm;
    logic       dec_legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign i_imm     = {{20{instr[31]}}, instr[31:20]};
    assign shamt_imm = {27'b0, instr[24:20]};
    assign u_imm     = {instr[31:12], 12'b0};

    always_comb begin
        dec_legal   = 1'b1;
        dec_op      = alu_add;
        dec_imm     = i_imm;
        dec_use_imm = 1'b1;
        case (opcode)
            opc_op: begin
                dec_use_imm = 1'b0;
                case (funct3)
                    3'b000:  dec_op = funct7[5] ? alu_sub : alu_add;
                    3'b001:  dec_op = alu_sll;
                    3'b010:  dec_op = alu_slt;
                    3'b011:  dec_op = alu_sltu;
                    3'b100:  dec_op = alu_xor;
                    3'b101:  dec_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  dec_op = alu_or;
                    default: dec_op = alu_and;
                endcase
                // the alternate funct7 only exists for sub and sra.
                if (funct7 != f7_base && funct7 != f7_alt) begin
                    dec_legal = 1'b0;
                end else if (funct7 == f7_alt && funct3 != 3'b000 && funct3 != 3'b101) begin
                    dec_legal = 1'b0;
                end
            end
            opc_op_imm: begin
                case (funct3)
                    3'b000:  dec_op = alu_add;
                    3'b001: begin
                        dec_op  = alu_sll;
                        dec_imm = shamt_imm;
                    end
                    3'b010:  dec_op = alu_slt;
                    3'b011:  dec_op = alu_sltu;
                    3'b100:  dec_op = alu_xor;
                    3'b101: begin
                        dec_op  = funct7[5] ? alu_sra : alu_srl;
                        dec_imm = shamt_imm;
                    end
                    3'b110:  dec_op = alu_or;
                    default: dec_op = alu_and;
                endcase
                // shift immediates keep funct7 in the upper bits.
                if (funct3 == 3'b001 && funct7 != f7_base) begin
                    dec_legal = 1'b0;
                end else if (funct3 == 3'b101 && funct7 != f7_base && funct7 != f7_alt) begin
                    dec_legal = 1'b0;
                end
            end
            opc_lui: begin
                dec_op  = alu_pass_imm;
                dec_imm = u_imm;
            end
            default: begin
                dec_legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            ex_valid <= instr_valid && dec_legal;
            illegal  <= instr_valid && !dec_legal;
        end
    end

    // payload only moves on a strobe.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_op      <= dec_op;
            ex_rs1     <= instr[19:15];
            ex_rs2     <= instr[24:20];
            ex_rd      <= instr[11:7];
            ex_imm     <= dec_imm;
            ex_use_imm <= dec_use_imm;
        end
    end

endmodule

// File: reg_file.sv
`include "rv_exec_params.svh"

module reg_file import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    localparam int reg_num = 2 ** `RV_LEN_REG_ADDR;

    localparam word_t sp_init = word_t'(1) << `RV_LEN_MEMDATA_ADDR;
    localparam word_t gp_init = `RV_HEAP_POINTER_INIT;

    // x0 has no storage.
    word_t regs [1:reg_num-1];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 1; i < reg_num; i++) begin
                regs[i] <= '0;
            end
            // stack and global pointers.
            regs[2] <= sp_init;
            regs[3] <= gp_init;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_rv_exec_top -f rv_exec_top.f

./obj_dir/Vtb_rv_exec_top

// File: rv_exec_params.svh
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// width of a data word.
`define RV_LEN_WORD 32

// register address width for 32 registers.
`define RV_LEN_REG_ADDR 5

// data memory address width.
// the stack pointer starts just past the top of data memory.
`define RV_LEN_MEMDATA_ADDR 16

// reset value of the global pointer x3.
`define RV_HEAP_POINTER_INIT 32'h0000_8000

`endif

// File: rv_exec_pkg.sv
`include "rv_exec_params.svh"

package rv_exec_pkg;

    typedef logic [`RV_LEN_WORD-1:0]     word_t;
    typedef logic [`RV_LEN_REG_ADDR-1:0] reg_addr_t;
    typedef logic [31:0]                 instr_t;
    typedef logic [15:0]                 count_t;

    // the alu functions plus a pass code that serves lui.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_imm
    } alu_op_t;

endpackage

// File: rv_exec_stimulus.txt
# columns: instr (hex), gap (idle cycles before, decimal), kind (0 result, 1 illegal),
#          rd (decimal), data (hex); text after the fifth column is ignored.
00000513 1 0 10 00000000  # addi x10, x0, 0
00008593 0 0 11 00000000  # addi x11, x1, 0
00010613 0 0 12 00010000  # addi x12, x2, 0
00018693 2 0 13 00008000  # addi x13, x3, 0
800002B7 1 0 5  80000000  # lui x5, 0x80000
FF000313 0 0 6  FFFFFFF0  # addi x6, x0, -16
06400393 0 0 7  00000064  # addi x7, x0, 100
12345437 3 0 8  12345000  # lui x8, 0x12345
67840413 0 0 8  12345678  # addi x8, x8, 0x678
00300493 0 0 9  00000003  # addi x9, x0, 3
00838733 1 0 14 123456DC  # add x14, x7, x8
408387B3 0 0 15 EDCBA9EC  # sub x15, x7, x8
00941833 0 0 16 91A2B3C0  # sll x16, x8, x9
007328B3 2 0 17 00000001  # slt x17, x6, x7
00733933 0 0 18 00000000  # sltu x18, x6, x7
006449B3 0 0 19 EDCBA988  # xor x19, x8, x6
00935A33 1 0 20 1FFFFFFE  # srl x20, x6, x9
40935AB3 0 0 21 FFFFFFFE  # sra x21, x6, x9
00746B33 0 0 22 1234567C  # or x22, x8, x7
00647BB3 0 0 23 12345670  # and x23, x8, x6
4092DC33 3 0 24 F0000000  # sra x24, x5, x9
0092DCB3 0 0 25 10000000  # srl x25, x5, x9
0062AD33 0 0 26 00000001  # slt x26, x5, x6
00533DB3 1 0 27 00000000  # sltu x27, x6, x5
0063BE33 0 0 28 00000001  # sltu x28, x7, x6
00649EB3 0 0 29 00030000  # sll x29, x9, x6
FFF32513 2 0 10 00000001  # slti x10, x6, -1
FFF3B593 0 0 11 00000001  # sltiu x11, x7, -1
0323A613 0 0 12 00000000  # slti x12, x7, 50
FFF44693 0 0 13 EDCBA987  # xori x13, x8, -1
7003E713 1 0 14 00000764  # ori x14, x7, 0x700
0FF47793 0 0 15 00000078  # andi x15, x8, 0xff
F0037813 0 0 16 FFFFFF00  # andi x16, x6, -256
00439893 0 0 17 00000640  # slli x17, x7, 4
00435913 0 0 18 0FFFFFFF  # srli x18, x6, 4
40435993 2 0 19 FFFFFFFF  # srai x19, x6, 4
41F2DA13 0 0 20 FFFFFFFF  # srai x20, x5, 31
01F2DA93 0 0 21 00000001  # srli x21, x5, 31
98840B13 1 0 22 12345000  # addi x22, x8, -0x678
7FF00B93 0 0 23 000007FF  # addi x23, x0, 2047
80000C13 0 0 24 FFFFF800  # addi x24, x0, -2048
FFFFFCB7 0 0 25 FFFFF000  # lui x25, 0xfffff
00528D33 0 0 26 00000000  # add x26, x5, x5
00500093 3 0 1  00000005  # addi x1, x0, 5
001080B3 0 0 1  0000000A  # add x1, x1, x1
00209093 0 0 1  00000028  # slli x1, x1, 2
FFF08113 0 0 2  00000027  # addi x2, x1, -1
401101B3 0 0 3  FFFFFFFF  # sub x3, x2, x1
0021C233 0 0 4  FFFFFFD8  # xor x4, x3, x2
40125213 0 0 4  FFFFFFEC  # srai x4, x4, 1
00127233 0 0 4  00000028  # and x4, x4, x1
00138013 2 0 0  00000065  # addi x0, x7, 1
00700F33 0 0 30 00000064  # add x30, x0, x7
00000F93 2 0 31 00000000  # addi x31, x0, 0
00042383 0 1 0  00000000  # lw x7, 0(x8)
02738433 0 1 0  00000000  # op with funct7 0x01
407394B3 1 1 0  00000000  # sll with funct7 0x20
00038513 0 0 10 00000064  # addi x10, x7, 0
00040593 0 0 11 12345678  # addi x11, x8, 0
00048613 0 0 12 00000003  # addi x12, x9, 0
40139693 2 1 0  00000000  # slli with funct7 0x20
00068693 0 0 13 EDCBA987  # addi x13, x13, 0
00742023 1 1 0  00000000  # sw x7, 0(x8)

// File: rv_exec_top.f
+incdir+.
rv_exec_pkg.sv
instr_decoder.sv
reg_file.sv
alu.sv
writeback_stage.sv
rv_exec_top.sv
tb_rv_exec_top.sv

// File: rv_exec_top.sv
module rv_exec_top import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      illegal,
    output count_t    retired
);

    logic      ex_valid;
    alu_op_t   ex_op;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    word_t     ex_imm;
    logic      ex_use_imm;

    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;

    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    instr_decoder u_decoder (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rd       (ex_rd),
        .ex_imm      (ex_imm),
        .ex_use_imm  (ex_use_imm),
        .illegal     (illegal)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rstn     (rstn),
        .rs1_addr (ex_rs1),
        .rs2_addr (ex_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    alu u_alu (
        .op       (ex_op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (ex_imm),
        .use_imm  (ex_use_imm),
        .result   (alu_result)
    );

    writeback_stage u_writeback (
        .clk      (clk),
        .rstn     (rstn),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .result   (alu_result),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .retired  (retired)
    );

endmodule

// File: tb_rv_exec_top.sv
module tb_rv_exec_top import rv_exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic      clk;
    logic      rstn;
    logic      instr_valid;
    instr_t    instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      illegal;
    count_t    retired;

    // vectors as read from the stimulus file.
    instr_t    vec_instr[$];
    int        vec_gap[$];
    bit        vec_is_illegal[$];
    reg_addr_t vec_rd[$];
    word_t     vec_data[$];
    int        total_gap = 0;
    bit        vectors_loaded = 1'b0;

    // expected results in retire order.
    reg_addr_t exp_rd_q[$];
    word_t     exp_data_q[$];
    int        illegal_issued = 0;
    int        illegal_seen = 0;
    count_t    legal_count = '0;
    count_t    results_seen = '0;
    reg_addr_t mon_rd;
    word_t     mon_data;

    rv_exec_top dut (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal),
        .retired     (retired)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          got;
        int          fields;
        string       line;
        logic [31:0] word_in;
        int          gap_in;
        int          kind_in;
        int          rd_in;
        logic [31:0] data_in;
        fd = $fopen("rv_exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open rv_exec_stimulus.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            // comment and blank lines carry no vector.
            if (got > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %d %d %d %h", word_in, gap_in, kind_in, rd_in,
                                 data_in);
                if (fields != 5) begin
                    $display("malformed line in stimulus file: %s", line);
                    abort_run();
                end
                vec_instr.push_back(word_in);
                vec_gap.push_back(gap_in);
                vec_is_illegal.push_back(kind_in != 0);
                vec_rd.push_back(reg_addr_t'(rd_in));
                vec_data.push_back(data_in);
                total_gap += gap_in;
            end
        end
        $fclose(fd);
        if (vec_instr.size() == 0) begin
            $display("stimulus file holds no vectors");
            abort_run();
        end
    endtask

    // idle cycles first, then one strobe.
    task automatic issue_vector(input int idx);
        repeat (vec_gap[idx]) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            instr       = '0;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = vec_instr[idx];
        if (vec_is_illegal[idx]) begin
            illegal_issued++;
        end else begin
            exp_rd_q.push_back(vec_rd[idx]);
            exp_data_q.push_back(vec_data[idx]);
            legal_count = legal_count + count_t'(1);
        end
    endtask

    initial begin
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        load_vectors();
        vectors_loaded = 1'b1;

        repeat (10) @(posedge clk);
        #1;
        if (wb_valid !== 1'b0 || illegal !== 1'b0) begin
            $display("wb_valid or illegal is not low during reset");
            abort_run();
        end
        check_count("retired", '0, retired);
        rstn = 1'b1;

        for (int i = 0; i < vec_instr.size(); i++) begin
            issue_vector(i);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;

        while (exp_rd_q.size() != 0 || illegal_seen != illegal_issued) begin
            @(posedge clk);
        end
        // a few quiet cycles catch stray pulses.
        repeat (4) @(posedge clk);
        check_count("retired", legal_count, retired);
        $display("Simulation PASSED");
        $finish;
    end

    // outputs are sampled on the falling edge, well away from updates.
    always @(negedge clk) begin
        if (rstn) begin
            if (illegal) begin
                if (illegal_seen == illegal_issued) begin
                    if (exp_rd_q.size() != 0) begin
                        $display("illegal pulse where a result was expected at %0t", $time);
                        abort_run();
                    end else begin
                        $display("illegal pulse with nothing expected at %0t", $time);
                        abort_run();
                    end
                end
                illegal_seen++;
            end
            if (wb_valid) begin
                if (exp_rd_q.size() == 0) begin
                    $display("wb_valid pulse with nothing expected at %0t", $time);
                    abort_run();
                end
                mon_rd   = exp_rd_q.pop_front();
                mon_data = exp_data_q.pop_front();
                check_reg("wb_rd", mon_rd, wb_rd);
                check_word("wb_data", mon_data, wb_data);
                results_seen = results_seen + count_t'(1);
                check_count("retired", results_seen, retired);
            end
        end
    end

    initial begin
        int limit;
        wait (vectors_loaded);
        limit = 10 + vec_instr.size() * 4 + total_gap;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        abort_run();
    end

endmodule

// File: writeback_stage.sv
module writeback_stage import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      ex_valid,
    input  reg_addr_t ex_rd,
    input  word_t     result,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output count_t    retired
);

    // write lands on the same edge that raises wb_valid.
    // x0 still retires but is never written.
    assign wr_en   = ex_valid && (ex_rd != '0);
    assign wr_addr = ex_rd;
    assign wr_data = result;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
            retired  <= '0;
        end else begin
            wb_valid <= ex_valid;
            if (ex_valid) begin
                retired <= retired + count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd   <= ex_rd;
            wb_data <= result;
        end
    end

endmodule
